//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= cacheTagTb
FILELIST  ?= vlog.f
PASS_MSG  := Regression passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o simv
	@out="$$(./obj_dir/simv 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- design/cacheTagPkg.sv
`include "cacheTagSettings.svh"

package cacheTagPkg;

  typedef logic [`SET_WIDTH-1:0] setIdx_t;
  typedef logic [`TAG_WIDTH-1:0] tag_t;
  typedef logic [$clog2(`WAY_COUNT)-1:0] way_t;

  // a stored entry keeps the tag in the low bits with valid and dirty above it and zeros on top.
  typedef logic [31:0] tagEntry_t;

  localparam int validBit = `TAG_WIDTH;
  localparam int dirtyBit = `TAG_WIDTH + 1;

  typedef enum logic [2:0] {
    stIdle,
    stProbe,  // row read is in flight.
    stEvict,  // row is out, victim is chosen and reported.
    stWrite,  // new entry goes into the victim way.
    stFlush   // one set is cleared per cycle.
  } refillState_t;

endpackage

//--- design/cacheTagSettings.svh
`ifndef CACHE_TAG_SETTINGS_SVH
`define CACHE_TAG_SETTINGS_SVH

// Geometry of the tag store. The way logic is written for four ways.

`define SET_WIDTH 8  // 256 sets.

`define TAG_WIDTH 21  // upper address bits kept per line.

`define WAY_COUNT 4

`endif

//--- design/cacheTagStore.sv
`include "cacheTagSettings.svh"

module cacheTagStore (
  input  logic                 clk,
  input  cacheTagPkg::setIdx_t lookupSet,
  input  cacheTagPkg::tag_t    lookupTag,
  input  logic                 lookupWrite,
  input  logic                 lookupValid,
  output logic                 isHit,
  output cacheTagPkg::way_t    hitBlockNum,
  output logic                 resultValid,
  tagReplaceIf.store           rep
);

  cacheTagPkg::setIdx_t   setQ;
  cacheTagPkg::tag_t      tagQ;
  logic                   writeQ;
  logic                   validQ;
  cacheTagPkg::setIdx_t   readAddress;
  cacheTagPkg::setIdx_t   writeAddress;
  cacheTagPkg::way_t      writeCh;
  cacheTagPkg::tagEntry_t writeTag;
  cacheTagPkg::tagEntry_t readHitTag;
  cacheTagPkg::tagEntry_t dirtyTag;
  logic                   writeEnable;
  logic                   dirtyUpdate;

  // the request rides alongside the RAM read so the compare sees the matching row.
  always_ff @(posedge clk) begin
    setQ <= lookupSet;
    tagQ <= lookupTag;
    writeQ <= lookupWrite;
    validQ <= lookupValid && !rep.sel;
  end

  assign dirtyTag = readHitTag | (cacheTagPkg::tagEntry_t'(1) << cacheTagPkg::dirtyBit);
  assign dirtyUpdate = validQ && writeQ && isHit;  // write hit marks its line dirty.

  assign readAddress = rep.sel ? rep.readAddress : lookupSet;
  assign writeAddress = rep.sel ? rep.writeAddress : setQ;
  assign writeCh = rep.sel ? rep.writeChannel : hitBlockNum;
  assign writeTag = rep.sel ? rep.writeData : dirtyTag;
  assign writeEnable = rep.sel ? rep.writeEnable : dirtyUpdate;

  tagWayArray array_i (
    .clk            (clk),
    .readAddress    (readAddress),
    .readCh         (rep.readChannel),
    .readTag        (rep.readData),
    .readHitTag     (readHitTag),
    .writeAddress   (writeAddress),
    .writeCh        (writeCh),
    .writeTag       (writeTag),
    .writeEnable    (writeEnable),
    .tag            (tagQ),
    .isHit          (isHit),
    .hitBlockNum    (hitBlockNum),
    .isHaveFreeBlock(rep.isHaveFreeBlock),
    .freeBlockNum   (rep.freeBlockNum)
  );

  assign resultValid = validQ;

endmodule

//--- design/cacheTagTop.sv
`include "cacheTagSettings.svh"

module cacheTagTop (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 lookupValid,
  input  cacheTagPkg::setIdx_t lookupSet,
  input  cacheTagPkg::tag_t    lookupTag,
  input  logic                 lookupWrite,
  output logic                 resultValid,
  output logic                 lookupHit,
  output cacheTagPkg::way_t    lookupWay,
  input  logic                 refillStart,
  input  cacheTagPkg::setIdx_t refillSet,
  input  cacheTagPkg::tag_t    refillTag,
  input  logic                 flushStart,
  output logic                 busy,
  output logic                 refillDone,
  output cacheTagPkg::way_t    refillWay,
  output logic                 evictValid,
  output cacheTagPkg::tag_t    evictTag,
  output logic                 evictDirty,
  output logic                 flushDone
);

  logic lookupAccept;

  tagReplaceIf rep_i ();

  assign lookupAccept = lookupValid && !busy;  // lookups made while busy are dropped.

  cacheTagStore store_i (
    .clk        (clk),
    .lookupSet  (lookupSet),
    .lookupTag  (lookupTag),
    .lookupWrite(lookupWrite),
    .lookupValid(lookupAccept),
    .isHit      (lookupHit),
    .hitBlockNum(lookupWay),
    .resultValid(resultValid),
    .rep        (rep_i.store)
  );

  tagRefillCtrl ctrl_i (
    .clk        (clk),
    .rstN       (rstN),
    .refillStart(refillStart),
    .refillSet  (refillSet),
    .refillTag  (refillTag),
    .flushStart (flushStart),
    .busy       (busy),
    .refillDone (refillDone),
    .refillWay  (refillWay),
    .evictValid (evictValid),
    .evictTag   (evictTag),
    .evictDirty (evictDirty),
    .flushDone  (flushDone),
    .rep        (rep_i.ctrl)
  );

endmodule

//--- design/dualPortRam.sv
module dualPortRam #(
  parameter int WIDTH = 128,
  parameter int DEPTH = 256
) (
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] readAddress,
  output logic [WIDTH-1:0]         readData,
  input  logic [$clog2(DEPTH)-1:0] writeAddress,
  input  logic [WIDTH-1:0]         writeData,
  input  logic                     writeEnable,
  input  logic [WIDTH/8-1:0]       writeByteEnable
);

  logic [WIDTH-1:0] mem [DEPTH];

  // only the enabled bytes of the word change.
  always_ff @(posedge clk) begin
    if (writeEnable) begin
      for (int b = 0; b < WIDTH / 8; b++) begin
        if (writeByteEnable[b]) begin
          mem[writeAddress][b*8 +: 8] <= writeData[b*8 +: 8];
        end
      end
    end
  end

  // a read of the address being written returns the old word.
  always_ff @(posedge clk) begin
    readData <= mem[readAddress];
  end

endmodule

//--- design/tagRefillCtrl.sv
`include "cacheTagSettings.svh"

module tagRefillCtrl (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 refillStart,
  input  cacheTagPkg::setIdx_t refillSet,
  input  cacheTagPkg::tag_t    refillTag,
  input  logic                 flushStart,
  output logic                 busy,
  output logic                 refillDone,
  output cacheTagPkg::way_t    refillWay,
  output logic                 evictValid,
  output cacheTagPkg::tag_t    evictTag,
  output logic                 evictDirty,
  output logic                 flushDone,
  tagReplaceIf.ctrl            rep
);

  cacheTagPkg::refillState_t state;
  cacheTagPkg::setIdx_t      setQ;
  cacheTagPkg::tag_t         tagQ;
  cacheTagPkg::setIdx_t      flushCnt;
  cacheTagPkg::way_t         rrPtr;
  cacheTagPkg::way_t         victim;
  cacheTagPkg::way_t         victimQ;
  cacheTagPkg::tagEntry_t    newEntry;
  logic                      startRefill;
  logic                      startFlush;
  logic                      inFlush;

  // busy also covers the cycle that reports the refill.
  assign busy = (state != cacheTagPkg::stIdle) || refillDone;
  assign startRefill = !busy && refillStart;
  assign startFlush = !busy && flushStart && !refillStart;  // refill has priority.
  assign inFlush = state == cacheTagPkg::stFlush;

  assign victim = rep.isHaveFreeBlock ? rep.freeBlockNum : rrPtr;

  always_comb begin
    newEntry = '0;
    newEntry[`TAG_WIDTH-1:0] = tagQ;
    newEntry[cacheTagPkg::validBit] = 1'b1;
  end

  assign rep.sel = state != cacheTagPkg::stIdle;
  assign rep.readAddress = setQ;
  assign rep.readChannel = victim;
  assign rep.writeAddress = inFlush ? flushCnt : setQ;
  assign rep.writeChannel = victimQ;
  assign rep.writeEnable = inFlush || (state == cacheTagPkg::stWrite);
  assign rep.writeData = inFlush ? '0 : newEntry;  // a zero entry clears the whole row.

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= cacheTagPkg::stIdle;
      rrPtr <= '0;
      flushCnt <= '0;
      refillDone <= 1'b0;
      flushDone <= 1'b0;
    end else begin
      refillDone <= 1'b0;
      flushDone <= 1'b0;
      case (state)
        cacheTagPkg::stIdle: begin
          if (startRefill) begin
            state <= cacheTagPkg::stProbe;
          end else if (startFlush) begin
            state <= cacheTagPkg::stFlush;
            flushCnt <= '0;
          end
        end
        cacheTagPkg::stProbe: begin
          state <= cacheTagPkg::stEvict;
        end
        cacheTagPkg::stEvict: begin
          state <= cacheTagPkg::stWrite;
          if (!rep.isHaveFreeBlock) begin
            rrPtr <= rrPtr + 1'b1;  // pointer moves only when a valid line is pushed out.
          end
        end
        cacheTagPkg::stWrite: begin
          state <= cacheTagPkg::stIdle;
          refillDone <= 1'b1;
        end
        cacheTagPkg::stFlush: begin
          flushCnt <= flushCnt + 1'b1;
          if (&flushCnt) begin
            state <= cacheTagPkg::stIdle;
            flushDone <= 1'b1;
          end
        end
        default: begin
          state <= cacheTagPkg::stIdle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (startRefill) begin
      setQ <= refillSet;
      tagQ <= refillTag;
    end
    if (state == cacheTagPkg::stEvict) begin
      victimQ <= victim;
      evictValid <= rep.readData[cacheTagPkg::validBit];
      evictTag <= rep.readData[`TAG_WIDTH-1:0];
      evictDirty <= rep.readData[cacheTagPkg::dirtyBit];
    end
  end

  assign refillWay = victimQ;

endmodule

//--- design/tagReplaceIf.sv
`include "cacheTagSettings.svh"

interface tagReplaceIf;

  logic                   sel;  // replacement side owns the array while high.
  cacheTagPkg::setIdx_t   readAddress;
  cacheTagPkg::way_t      readChannel;
  cacheTagPkg::tagEntry_t readData;
  cacheTagPkg::setIdx_t   writeAddress;
  cacheTagPkg::way_t      writeChannel;
  logic                   writeEnable;
  cacheTagPkg::tagEntry_t writeData;
  logic                   isHaveFreeBlock;
  cacheTagPkg::way_t      freeBlockNum;

  modport ctrl (
    output sel, readAddress, readChannel,
    output writeAddress, writeChannel, writeEnable, writeData,
    input  readData, isHaveFreeBlock, freeBlockNum
  );

  modport store (
    input  sel, readAddress, readChannel,
    input  writeAddress, writeChannel, writeEnable, writeData,
    output readData, isHaveFreeBlock, freeBlockNum
  );

endinterface

//--- design/tagWayArray.sv
`include "cacheTagSettings.svh"

module tagWayArray (
  input  logic                   clk,
  input  cacheTagPkg::setIdx_t   readAddress,
  input  cacheTagPkg::way_t      readCh,
  output cacheTagPkg::tagEntry_t readTag,
  output cacheTagPkg::tagEntry_t readHitTag,
  input  cacheTagPkg::setIdx_t   writeAddress,
  input  cacheTagPkg::way_t      writeCh,
  input  cacheTagPkg::tagEntry_t writeTag,
  input  logic                   writeEnable,
  input  cacheTagPkg::tag_t      tag,
  output logic                   isHit,
  output cacheTagPkg::way_t      hitBlockNum,
  output logic                   isHaveFreeBlock,
  output cacheTagPkg::way_t      freeBlockNum
);

  localparam int entryWidth = $bits(cacheTagPkg::tagEntry_t);
  localparam int entryBytes = entryWidth / 8;
  localparam int rowWidth = `WAY_COUNT * entryWidth;

  logic [rowWidth-1:0]        rowRead;
  logic [rowWidth-1:0]        rowWrite;
  logic [rowWidth/8-1:0]      byteEn;
  logic [`WAY_COUNT-1:0]      wayMask;
  logic [`WAY_COUNT-1:0]      wayValid;
  logic [`WAY_COUNT-1:0]      wayHit;
  cacheTagPkg::tagEntry_t     rowEntry [`WAY_COUNT];

  assign rowWrite = {`WAY_COUNT{writeTag}};

  // An entry with its valid bit clear lands in every way at once, so a flush clears a row
  // in a single write.
  assign wayMask = writeTag[cacheTagPkg::validBit] ? (`WAY_COUNT'(1) << writeCh) : '1;

  for (genvar w = 0; w < `WAY_COUNT; w++) begin : gWay
    assign rowEntry[w] = rowRead[w*entryWidth +: entryWidth];
    assign byteEn[w*entryBytes +: entryBytes] = {entryBytes{wayMask[w]}};
    assign wayValid[w] = rowEntry[w][cacheTagPkg::validBit];
    assign wayHit[w] = wayValid[w] && (rowEntry[w][`TAG_WIDTH-1:0] == tag);
  end

  dualPortRam #(
    .WIDTH(rowWidth),
    .DEPTH(2 ** `SET_WIDTH)
  ) tagRam_i (
    .clk            (clk),
    .readAddress    (readAddress),
    .readData       (rowRead),
    .writeAddress   (writeAddress),
    .writeData      (rowWrite),
    .writeEnable    (writeEnable),
    .writeByteEnable(byteEn)
  );

  // scanning downwards leaves the lowest matching way in each result.
  always_comb begin
    hitBlockNum = '0;
    freeBlockNum = '0;
    for (int w = `WAY_COUNT - 1; w >= 0; w--) begin
      if (wayHit[w]) begin
        hitBlockNum = cacheTagPkg::way_t'(w);
      end
      if (!wayValid[w]) begin
        freeBlockNum = cacheTagPkg::way_t'(w);
      end
    end
  end

  assign isHit = |wayHit;
  assign isHaveFreeBlock = ~&wayValid;

  assign readTag = rowEntry[readCh];
  assign readHitTag = rowEntry[hitBlockNum];

endmodule

//--- dv/cacheTagChecker.sv
module cacheTagChecker (
  input logic clk,
  input logic rstN,
  input logic lookupValid,
  input logic resultValid,
  input logic busy,
  input logic refillStart,
  input logic flushStart,
  input logic refillDone,
  input logic flushDone
);

  int failCount = 0;

  // outputs settle low once reset has been seen.
  aResetQuiet: assert property (@(posedge clk) !rstN |=> !busy && !refillDone && !flushDone)
    else begin failCount++; $error("outputs active after reset"); end

  aRefillBusy: assert property (@(posedge clk) disable iff (!rstN)
    refillStart && !busy |=> busy)
    else begin failCount++; $error("refill start did not raise busy"); end

  aRefillDone: assert property (@(posedge clk) disable iff (!rstN)
    refillStart && !busy |-> ##4 refillDone)
    else begin failCount++; $error("refill done not four cycles after start"); end

  aRefillEnd: assert property (@(posedge clk) disable iff (!rstN)
    refillDone |=> !busy && !refillDone)
    else begin failCount++; $error("refill done not a single pulse ending busy"); end

  aFlushBusy: assert property (@(posedge clk) disable iff (!rstN)
    flushStart && !refillStart && !busy |=> busy)
    else begin failCount++; $error("flush start did not raise busy"); end

  aFlushEnd: assert property (@(posedge clk) disable iff (!rstN)
    flushDone |=> !flushDone && !busy)
    else begin failCount++; $error("flush done not a single pulse ending busy"); end

  aLookupResult: assert property (@(posedge clk) disable iff (!rstN)
    lookupValid && !busy |=> resultValid)
    else begin failCount++; $error("accepted lookup gave no result"); end

  // a lookup made while busy must vanish.
  aLookupDrop: assert property (@(posedge clk) disable iff (!rstN)
    !(lookupValid && !busy) |=> !resultValid)
    else begin failCount++; $error("result without an accepted lookup"); end

endmodule

//--- dv/cacheTagTb.sv
`include "cacheTagSettings.svh"

module cacheTagTb;

  logic clk, rstN, lookupValid, lookupWrite, refillStart, flushStart;
  cacheTagPkg::setIdx_t lookupSet, refillSet;
  cacheTagPkg::tag_t lookupTag, refillTag, evictTag;
  logic resultValid, lookupHit, busy, refillDone, evictValid, evictDirty, flushDone;
  cacheTagPkg::way_t lookupWay, refillWay;
  int errors = 0;
  int seed;
  logic mValid [2**`SET_WIDTH][`WAY_COUNT];
  logic mDirty [2**`SET_WIDTH][`WAY_COUNT];
  cacheTagPkg::tag_t mTag [2**`SET_WIDTH][`WAY_COUNT];
  cacheTagPkg::way_t mPtr = '0;

  cacheTagTop dut_i (.*);

  bind cacheTagTop cacheTagChecker chk_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abortRun(input string why);
    $display("run stopped: %s", why);
    $display("Regression failed");
    $finish;
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("error: %s is 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic flushAll();
    int cnt;
    cnt = 0;
    @(posedge clk) flushStart <= 1'b1;
    @(posedge clk) flushStart <= 1'b0;
    @(negedge clk);
    while (!flushDone && cnt < 400) begin
      @(negedge clk);
      cnt++;
    end
    if (!flushDone) abortRun("flushDone never came");
    foreach (mValid[s, w]) begin
      mValid[s][w] = 1'b0;
      mDirty[s][w] = 1'b0;
    end
  endtask

  task automatic lookup(input cacheTagPkg::setIdx_t s, input cacheTagPkg::tag_t t,
                        input logic wr);
    logic expHit;
    cacheTagPkg::way_t expWay;
    int cnt;
    expHit = 1'b0;
    expWay = '0;
    cnt = 0;
    for (int w = `WAY_COUNT - 1; w >= 0; w--) begin
      if (mValid[s][w] && mTag[s][w] == t) begin
        expHit = 1'b1;
        expWay = cacheTagPkg::way_t'(w);
      end
    end
    @(posedge clk);
    lookupValid <= 1'b1;
    lookupSet <= s;
    lookupTag <= t;
    lookupWrite <= wr;
    @(posedge clk);
    lookupValid <= 1'b0;
    lookupWrite <= 1'b0;
    @(negedge clk);
    while (!resultValid && cnt < 4) begin
      @(negedge clk);
      cnt++;
    end
    if (!resultValid) abortRun("lookup result never came");
    checkEq("lookupHit", 32'(lookupHit), 32'(expHit));
    if (expHit) begin
      checkEq("lookupWay", 32'(lookupWay), 32'(expWay));
      if (wr) mDirty[s][expWay] = 1'b1;
    end
  endtask

  task automatic refill(input cacheTagPkg::setIdx_t s, input cacheTagPkg::tag_t t);
    cacheTagPkg::way_t expWay;
    logic expEvict;
    int cnt;
    expWay = mPtr;
    expEvict = 1'b1;
    cnt = 0;
    for (int w = `WAY_COUNT - 1; w >= 0; w--) begin
      if (!mValid[s][w]) begin
        expWay = cacheTagPkg::way_t'(w);
        expEvict = 1'b0;
      end
    end
    @(posedge clk);
    refillStart <= 1'b1;
    refillSet <= s;
    refillTag <= t;
    @(posedge clk) refillStart <= 1'b0;
    @(negedge clk);
    while (!refillDone && cnt < 10) begin
      @(negedge clk);
      cnt++;
    end
    if (!refillDone) abortRun("refillDone never came");
    checkEq("refillWay", 32'(refillWay), 32'(expWay));
    checkEq("evictValid", 32'(evictValid), 32'(expEvict));
    if (expEvict) begin
      checkEq("evictTag", 32'(evictTag), 32'(mTag[s][expWay]));
      checkEq("evictDirty", 32'(evictDirty), 32'(mDirty[s][expWay]));
      mPtr = mPtr + 1'b1;  // the victim pointer only moves on a real eviction.
    end
    mValid[s][expWay] = 1'b1;
    mDirty[s][expWay] = 1'b0;
    mTag[s][expWay] = t;
    cnt = 0;
    while (busy && cnt < 10) begin
      @(negedge clk);
      cnt++;
    end
    if (busy) abortRun("busy stayed high after a refill");
  endtask

  initial begin
    #200000;
    abortRun("simulation ran past its time limit");
  end

  initial begin
    cacheTagPkg::setIdx_t s;
    cacheTagPkg::tag_t t;
    int doneCount;
    int resultCount;
    seed = 32'h9ecd_6684;
    rstN = 1'b0;
    lookupValid = 1'b0;
    lookupWrite = 1'b0;
    lookupSet = '0;
    lookupTag = '0;
    refillStart = 1'b0;
    refillSet = '0;
    refillTag = '0;
    flushStart = 1'b0;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkEq("resultValid", 32'(resultValid), 32'h0);
    checkEq("busy", 32'(busy), 32'h0);
    checkEq("refillDone", 32'(refillDone), 32'h0);
    checkEq("flushDone", 32'(flushDone), 32'h0);

    flushAll();
    repeat (8) lookup(cacheTagPkg::setIdx_t'($random(seed)), cacheTagPkg::tag_t'($random(seed)),
                      1'b0);

    // fill one set, then probe every way and a stranger.
    s = cacheTagPkg::setIdx_t'($random(seed));
    for (int i = 0; i < `WAY_COUNT; i++) refill(s, cacheTagPkg::tag_t'($random(seed)));
    for (int w = 0; w < `WAY_COUNT; w++) lookup(s, mTag[s][w], 1'b0);
    lookup(s, cacheTagPkg::tag_t'($random(seed)), 1'b0);

    lookup(s, mTag[s][0], 1'b1);
    lookup(s, mTag[s][2], 1'b1);
    for (int i = 0; i < 5; i++) refill(s, cacheTagPkg::tag_t'($random(seed)));
    for (int w = 0; w < `WAY_COUNT; w++) lookup(s, mTag[s][w], 1'b0);

    // a second refill and a lookup land while the first refill is running.
    s = s + 1'b1;
    t = cacheTagPkg::tag_t'($random(seed));
    doneCount = 0;
    resultCount = 0;
    @(posedge clk);
    refillStart <= 1'b1;
    refillSet <= s;
    refillTag <= t;
    @(posedge clk);
    refillTag <= t + 1'b1;
    lookupValid <= 1'b1;
    lookupSet <= s;
    lookupTag <= t;
    @(posedge clk);
    refillStart <= 1'b0;
    lookupValid <= 1'b0;
    repeat (12) begin
      @(negedge clk);
      if (refillDone) doneCount++;
      if (resultValid) resultCount++;
    end
    checkEq("refillDone count", 32'(doneCount), 32'd1);
    checkEq("resultValid count", 32'(resultCount), 32'd0);
    mValid[s][0] = 1'b1;
    mDirty[s][0] = 1'b0;
    mTag[s][0] = t;
    lookup(s, t, 1'b0);
    lookup(s, t + 1'b1, 1'b0);

    repeat (4) @(posedge clk);
    $display("checks done: %0d errors, %0d assertion failures", errors, dut_i.chk_i.failCount);
    if (errors == 0 && dut_i.chk_i.failCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+design
design/cacheTagPkg.sv
design/tagReplaceIf.sv
design/dualPortRam.sv
design/tagWayArray.sv
design/cacheTagStore.sv
design/tagRefillCtrl.sv
design/cacheTagTop.sv
dv/cacheTagChecker.sv
dv/cacheTagTb.sv
